// ==== source/cart_pkg.sv ====
package cart_pkg;

   ////////////////////////////////////////////////////////////
   // Slot window
   ////////////////////////////////////////////////////////////
   localparam int         slot_count     = 12;
   localparam int         snes_last_slot = 5;
   localparam logic [3:0] slot_idle      = 4'd12;

   // Per-slot patterns, bit n is slot n, top bit is the idle index
   localparam logic [slot_count:0] pat_snes_slots    = 13'b0_0000_0011_1111;
   localparam logic [slot_count:0] pat_avr_slots     = 13'b0_1111_1100_0000;
   localparam logic [slot_count:0] pat_snes_we       = 13'b0_0000_0001_1100;
   localparam logic [slot_count:0] pat_avr_we        = 13'b0_0011_0000_0000;
   localparam logic [slot_count:0] pat_avr_drive     = 13'b0_0111_1000_0000;
   localparam logic [slot_count:0] pat_snes_wr_latch = 13'b0_0000_0000_0010;
   localparam logic [slot_count:0] pat_snes_rd_latch = 13'b0_0000_0001_0000;
   localparam logic [slot_count:0] pat_avr_rd_latch  = 13'b0_0100_0000_0000;
   localparam logic [slot_count:0] pat_avr_done      = 13'b0_1000_0000_0000;

   // Mapper codes
   localparam logic [3:0] map_hirom = 4'd0;
   localparam logic [3:0] map_lorom = 4'd1;

   // AVR command opcodes, upper nibble of the command byte
   localparam logic [3:0] cmd_set_addr = 4'h0;
   localparam logic [3:0] cmd_set_map  = 4'h1;
   localparam logic [3:0] cmd_set_save = 4'h2;
   localparam logic [3:0] cmd_read     = 4'h8;
   localparam logic [3:0] cmd_write    = 4'h9;
   localparam logic [3:0] cmd_none     = 4'hF;

   // Save RAM sits in the top 64K words
   localparam logic [19:0] saveram_base = 20'hF0000;

   ////////////////////////////////////////////////////////////
   // Types
   ////////////////////////////////////////////////////////////
   typedef struct packed {
      logic [7:0] hi;
      logic [7:0] lo;
   } byte_pair_t;

   // SRAM word, whole or as a lane pair
   typedef union packed {
      logic [15:0] word;
      byte_pair_t  bytes;
   } sram_word_u;

   typedef struct packed {
      logic [3:0]  mapper;
      logic [19:0] save_mask;
   } map_cfg_t;

   // Pending AVR access
   typedef struct packed {
      logic [23:0] addr;
      logic        write;
   } mem_req_t;

   typedef struct packed {
      logic sram_oe_n;
      logic sram_we_n;
      logic avr_phase;
      logic snes_wr_latch;
      logic snes_rd_latch;
      logic avr_wr_drive;
      logic avr_rd_latch;
      logic avr_done;
   } slot_ctl_t;

endpackage

// ==== source/spi_slave.sv ====
`timescale 1ns/100ps

module spi_slave (
   input  logic       CLK2,
   input  logic       rst_n,
   input  logic       spi_sck,
   input  logic       spi_mosi,
   input  logic       spi_ss,
   output logic       spi_miso,
   input  logic [7:0] tx_byte,
   output logic [7:0] rx_byte,
   output logic       cmd_ready,
   output logic       param_ready,
   output logic       start_msg,
   output logic       end_msg
);

   logic [2:0] sck_q;
   logic [2:0] ss_q;
   logic [1:0] mosi_q;
   logic [2:0] bit_cnt;
   logic [7:0] rx_shift;
   logic [7:0] tx_shift;
   logic       first_byte;
   logic       sck_rise;
   logic       sck_fall;
   logic       ss_active;
   logic       byte_done;

   // Edges seen after two sync stages
   assign sck_rise  = (sck_q[2:1] == 2'b01);
   assign sck_fall  = (sck_q[2:1] == 2'b10);
   assign ss_active = ~ss_q[1];
   assign start_msg = (ss_q[2:1] == 2'b10);
   assign end_msg   = (ss_q[2:1] == 2'b01);
   // Eighth rising edge closes a byte
   assign byte_done = ss_active & sck_rise & (bit_cnt == 3'd7);
   assign spi_miso  = tx_shift[7];

   ////////////////////////////////////////////////////////////
   // Synchronizers and receive control
   ////////////////////////////////////////////////////////////
   always_ff @(posedge CLK2) begin
      if (!rst_n) begin
         sck_q       <= 3'b000;
         ss_q        <= 3'b111;
         mosi_q      <= 2'b00;
         bit_cnt     <= 3'd0;
         first_byte  <= 1'b1;
         cmd_ready   <= 1'b0;
         param_ready <= 1'b0;
      end else begin
         sck_q       <= {sck_q[1:0], spi_sck};
         ss_q        <= {ss_q[1:0], spi_ss};
         mosi_q      <= {mosi_q[0], spi_mosi};
         // First byte of a message is the command
         cmd_ready   <= byte_done & first_byte;
         param_ready <= byte_done & ~first_byte;
         if (start_msg) begin
            bit_cnt    <= 3'd0;
            first_byte <= 1'b1;
         end else if (ss_active && sck_rise) begin
            bit_cnt <= bit_cnt + 3'd1;
            if (bit_cnt == 3'd7)
               first_byte <= 1'b0;
         end
      end
   end

   // MOSI sampled on rising SCK, MSB first
   always_ff @(posedge CLK2) begin
      if (ss_active && sck_rise)
         rx_shift <= {rx_shift[6:0], mosi_q[1]};
      if (byte_done)
         rx_byte <= {rx_shift[6:0], mosi_q[1]};
   end

   // MISO shifts on falling SCK, reload at each byte boundary
   always_ff @(posedge CLK2) begin
      if (!rst_n)
         tx_shift <= 8'h00;
      else if (start_msg)
         tx_shift <= tx_byte;
      else if (ss_active && sck_fall) begin
         if (bit_cnt == 3'd0)
            tx_shift <= tx_byte;
         else
            tx_shift <= {tx_shift[6:0], 1'b0};
      end
   end

endmodule

// ==== source/avr_cmd.sv ====
`timescale 1ns/100ps

module avr_cmd (
   input  logic               CLK2,
   input  logic               rst_n,
   input  logic               cmd_ready,
   input  logic               param_ready,
   input  logic               end_msg,
   input  logic [7:0]         rx_byte,
   output logic [7:0]         tx_byte,
   output cart_pkg::map_cfg_t map_cfg,
   output cart_pkg::mem_req_t avr_req,
   output logic [7:0]         avr_wdata,
   output logic               avr_pending,
   input  logic               avr_done,
   input  logic [7:0]         avr_rd_byte
);

   logic [3:0] opcode;
   logic [1:0] addr_cnt;

   // Last SRAM read goes out on the next SPI byte
   assign tx_byte = avr_rd_byte;

   ////////////////////////////////////////////////////////////
   // Command decode
   ////////////////////////////////////////////////////////////
   always_ff @(posedge CLK2) begin
      if (!rst_n) begin
         opcode      <= cart_pkg::cmd_none;
         addr_cnt    <= 2'd0;
         map_cfg     <= '{mapper: cart_pkg::map_hirom, save_mask: 20'd0};
         avr_req     <= '0;
         avr_pending <= 1'b0;
      end else begin
         if (cmd_ready) begin
            opcode   <= rx_byte[7:4];
            addr_cnt <= 2'd0;
            case (rx_byte[7:4])
               cart_pkg::cmd_set_map:
                  map_cfg.mapper <= rx_byte[3:0];
               // Save size 1K shifted by the code
               cart_pkg::cmd_set_save:
                  map_cfg.save_mask <= (20'd1024 << rx_byte[3:0]) - 20'd1;
               default: ;
            endcase
         end else if (end_msg) begin
            // Stray bytes after SS rises do nothing
            opcode <= cart_pkg::cmd_none;
         end

         // Access finished, step to next byte
         if (avr_done) begin
            avr_pending  <= 1'b0;
            avr_req.addr <= avr_req.addr + 24'd1;
         end

         if (param_ready) begin
            case (opcode)
               // Address arrives high byte first
               cart_pkg::cmd_set_addr: begin
                  if (addr_cnt != 2'd3) begin
                     avr_req.addr <= {avr_req.addr[15:0], rx_byte};
                     addr_cnt     <= addr_cnt + 2'd1;
                  end
               end
               cart_pkg::cmd_read: begin
                  avr_req.write <= 1'b0;
                  avr_pending   <= 1'b1;
               end
               cart_pkg::cmd_write: begin
                  avr_req.write <= 1'b1;
                  avr_pending   <= 1'b1;
               end
               default: ;
            endcase
         end
      end
   end

   // Write byte held until the AVR slots take it
   always_ff @(posedge CLK2) begin
      if (param_ready && opcode == cart_pkg::cmd_write)
         avr_wdata <= rx_byte;
   end

   // Sequencer only closes accesses this block opened
   a_done_pending: assert property (@(posedge CLK2) disable iff (!rst_n)
      avr_done |-> avr_pending);

endmodule

// ==== source/addr_map.sv ====
`timescale 1ns/100ps

module addr_map (
   input  logic [23:0]        snes_addr,
   input  cart_pkg::mem_req_t avr_req,
   input  cart_pkg::map_cfg_t map_cfg,
   input  logic               avr_phase,
   output logic [19:0]        sram_addr,
   output logic               sram_ble_n,
   output logic               sram_bhe_n,
   output logic               is_rom,
   output logic               is_saveram
);

   logic [7:0]  bank;
   logic [15:0] offs;
   logic        lorom;
   logic [20:0] rom_byte;
   logic [19:0] save_byte;
   logic [19:0] save_masked;
   logic        lane;

   assign bank        = snes_addr[23:16];
   assign offs        = snes_addr[15:0];
   assign lorom       = (map_cfg.mapper == cart_pkg::map_lorom);
   assign save_masked = save_byte & map_cfg.save_mask;

   ////////////////////////////////////////////////////////////
   // Region decode per mapper
   ////////////////////////////////////////////////////////////
   always_comb begin
      if (lorom) begin
         is_rom     = offs[15];
         is_saveram = (bank >= 8'h70) && (bank <= 8'h7D) && !offs[15];
         // Bank bit 6 falls past the 2 MB SRAM
         rom_byte   = {bank[5:0], offs[14:0]};
         save_byte  = {1'b0, bank[3:0], offs[14:0]};
      end else begin
         is_rom     = ((bank >= 8'h40) && (bank <= 8'h7D)) || (bank >= 8'hC0) || offs[15];
         // Banks 20-3F and A0-BF, offsets 6000-7FFF
         is_saveram = (bank[6:5] == 2'b01) && (offs[15:13] == 3'b011);
         rom_byte   = snes_addr[20:0];
         save_byte  = {7'd0, offs[12:0]};
      end
   end

   // Word address and lane, AVR slots use raw byte address
   always_comb begin
      if (avr_phase) begin
         sram_addr = avr_req.addr[20:1];
         lane      = avr_req.addr[0];
      end else if (is_saveram) begin
         sram_addr = cart_pkg::saveram_base + {1'b0, save_masked[19:1]};
         lane      = save_masked[0];
      end else begin
         sram_addr = rom_byte[20:1];
         lane      = rom_byte[0];
      end
   end

   // Odd byte on the high lane
   assign sram_ble_n = lane;
   assign sram_bhe_n = ~lane;

endmodule

// ==== source/data_path.sv ====
`timescale 1ns/100ps

module data_path (
   input  logic                 CLK2,
   input  logic                 rst_n,
   input  cart_pkg::slot_ctl_t  slot_ctl,
   input  logic                 byte_hi,
   input  logic [7:0]           snes_data_in,
   input  logic [7:0]           avr_wdata,
   input  cart_pkg::sram_word_u sram_rdata,
   output cart_pkg::sram_word_u sram_wdata,
   output logic                 sram_data_oe,
   output logic [7:0]           snes_data_out,
   output logic [7:0]           avr_rd_byte
);

   logic [7:0] snes_wr_byte;
   logic [7:0] rd_lane;
   logic [7:0] wr_byte;
   logic       hold_q;

   // Lane pick from the byte view
   assign rd_lane = byte_hi ? sram_rdata.bytes.hi : sram_rdata.bytes.lo;
   assign wr_byte = slot_ctl.avr_phase ? avr_wdata : snes_wr_byte;

   // Same byte on both lanes, BHE/BLE pick the one written
   always_comb begin
      sram_wdata.bytes.hi = wr_byte;
      sram_wdata.bytes.lo = wr_byte;
   end

   // Console write data stays one slot past WE rising
   assign sram_data_oe = slot_ctl.avr_wr_drive | ~slot_ctl.sram_we_n | hold_q;

   always_ff @(posedge CLK2) begin
      if (!rst_n)
         hold_q <= 1'b0;
      else
         hold_q <= ~slot_ctl.sram_we_n & ~slot_ctl.avr_phase;
   end

   ////////////////////////////////////////////////////////////
   // Data latches
   ////////////////////////////////////////////////////////////
   always_ff @(posedge CLK2) begin
      if (slot_ctl.snes_wr_latch)
         snes_wr_byte <= snes_data_in;
      // Held for the console until the next read
      if (slot_ctl.snes_rd_latch)
         snes_data_out <= rd_lane;
      if (slot_ctl.avr_rd_latch)
         avr_rd_byte <= rd_lane;
   end

endmodule

// ==== source/slot_sequencer.sv ====
`timescale 1ns/100ps

module slot_sequencer (
   input  logic                CLK2,
   input  logic                rst_n,
   input  logic                snes_rd_n,
   input  logic                snes_wr_n,
   input  logic                avr_pending,
   input  logic                avr_write,
   input  logic                is_saveram,
   output cart_pkg::slot_ctl_t slot_ctl
);

   logic [1:0] rd_sync;
   logic [1:0] wr_sync;
   logic       rw_s;
   logic       rw_q;
   logic       slot_start;
   logic [3:0] slot_idx;
   logic       snes_wr_cyc;
   logic       avr_act;
   logic       avr_wr_cyc;

   // Combined strobe, low while either RD or WR is low
   assign rw_s = rd_sync[1] & wr_sync[1];

   ////////////////////////////////////////////////////////////
   // Cycle start detection
   ////////////////////////////////////////////////////////////
   always_ff @(posedge CLK2) begin
      if (!rst_n) begin
         rd_sync    <= 2'b11;
         wr_sync    <= 2'b11;
         rw_q       <= 1'b1;
         slot_start <= 1'b0;
      end else begin
         rd_sync    <= {rd_sync[0], snes_rd_n};
         wr_sync    <= {wr_sync[0], snes_wr_n};
         rw_q       <= rw_s;
         // Falling edge, third flop after the pin
         slot_start <= rw_q & ~rw_s;
      end
   end

   // Slot index and captured cycle kinds
   always_ff @(posedge CLK2) begin
      if (!rst_n) begin
         slot_idx    <= cart_pkg::slot_idle;
         snes_wr_cyc <= 1'b0;
         avr_act     <= 1'b0;
         avr_wr_cyc  <= 1'b0;
      end else begin
         if (slot_start) begin
            // New start restarts the window
            slot_idx    <= 4'd0;
            snes_wr_cyc <= ~wr_sync[1];
         end else if (slot_idx != cart_pkg::slot_idle) begin
            // Slot 11 steps on to idle
            slot_idx <= slot_idx + 4'd1;
         end
         // AVR request sampled on entry to slot 6
         if (!slot_start && slot_idx == 4'(cart_pkg::snes_last_slot)) begin
            avr_act    <= avr_pending;
            avr_wr_cyc <= avr_write;
         end
      end
   end

   ////////////////////////////////////////////////////////////
   // Slot decode from the pattern tables
   ////////////////////////////////////////////////////////////
   always_comb begin
      slot_ctl.avr_phase     = cart_pkg::pat_avr_slots[slot_idx];
      slot_ctl.sram_oe_n     = ~((cart_pkg::pat_snes_slots[slot_idx] & ~snes_wr_cyc)
                               | (cart_pkg::pat_avr_slots[slot_idx] & avr_act & ~avr_wr_cyc));
      // Console writes only reach save RAM
      slot_ctl.sram_we_n     = ~((cart_pkg::pat_snes_we[slot_idx] & snes_wr_cyc & is_saveram)
                               | (cart_pkg::pat_avr_we[slot_idx] & avr_act & avr_wr_cyc));
      slot_ctl.snes_wr_latch = cart_pkg::pat_snes_wr_latch[slot_idx] & snes_wr_cyc;
      slot_ctl.snes_rd_latch = cart_pkg::pat_snes_rd_latch[slot_idx] & ~snes_wr_cyc;
      slot_ctl.avr_wr_drive  = cart_pkg::pat_avr_drive[slot_idx] & avr_act & avr_wr_cyc;
      slot_ctl.avr_rd_latch  = cart_pkg::pat_avr_rd_latch[slot_idx] & avr_act & ~avr_wr_cyc;
      slot_ctl.avr_done      = cart_pkg::pat_avr_done[slot_idx] & avr_act;
   end

   // SRAM never sees both strobes, whichever master owns the slot
   a_oe_we_excl: assert property (@(posedge CLK2) disable iff (!rst_n)
      slot_ctl.sram_oe_n || slot_ctl.sram_we_n);

   a_idx_range: assert property (@(posedge CLK2) disable iff (!rst_n)
      slot_idx <= cart_pkg::slot_idle);

endmodule

// ==== source/cart_ctrl_top.sv ====
`timescale 1ns/100ps

module cart_ctrl_top (
   input  logic                 CLK2,
   input  logic                 rst_n,
   input  logic [23:0]          snes_addr,
   input  logic                 snes_rd_n,
   input  logic                 snes_wr_n,
   input  logic [7:0]           snes_data_in,
   output logic [7:0]           snes_data_out,
   output logic                 snes_data_oe,
   output logic                 snes_data_dir,
   input  logic                 spi_sck,
   input  logic                 spi_mosi,
   input  logic                 spi_ss,
   output logic                 spi_miso,
   output logic [19:0]          sram_addr,
   input  cart_pkg::sram_word_u sram_rdata,
   output cart_pkg::sram_word_u sram_wdata,
   output logic                 sram_data_oe,
   output logic                 sram_oe_n,
   output logic                 sram_we_n,
   output logic                 sram_bhe_n,
   output logic                 sram_ble_n
);

   logic [7:0]          rx_byte;
   logic [7:0]          tx_byte;
   logic                cmd_ready;
   logic                param_ready;
   logic                end_msg;
   cart_pkg::map_cfg_t  map_cfg;
   cart_pkg::mem_req_t  avr_req;
   logic [7:0]          avr_wdata;
   logic                avr_pending;
   logic [7:0]          avr_rd_byte;
   cart_pkg::slot_ctl_t slot_ctl;
   logic                is_rom;
   logic                is_saveram;

   // Console buffer on only for reads of mapped regions
   assign snes_data_oe  = ~snes_rd_n & (is_rom | is_saveram);
   // High drives toward the console
   assign snes_data_dir = ~snes_rd_n;
   assign sram_oe_n     = slot_ctl.sram_oe_n;
   assign sram_we_n     = slot_ctl.sram_we_n;

   ////////////////////////////////////////////////////////////
   // AVR side
   ////////////////////////////////////////////////////////////
   spi_slave spi_slave_inst (
      .CLK2(CLK2), .rst_n(rst_n),
      .spi_sck(spi_sck), .spi_mosi(spi_mosi), .spi_ss(spi_ss), .spi_miso(spi_miso),
      .tx_byte(tx_byte), .rx_byte(rx_byte),
      .cmd_ready(cmd_ready), .param_ready(param_ready),
      .start_msg(), .end_msg(end_msg)
   );

   avr_cmd avr_cmd_inst (
      .CLK2(CLK2), .rst_n(rst_n),
      .cmd_ready(cmd_ready), .param_ready(param_ready), .end_msg(end_msg),
      .rx_byte(rx_byte), .tx_byte(tx_byte),
      .map_cfg(map_cfg), .avr_req(avr_req), .avr_wdata(avr_wdata),
      .avr_pending(avr_pending), .avr_done(slot_ctl.avr_done),
      .avr_rd_byte(avr_rd_byte)
   );

   ////////////////////////////////////////////////////////////
   // Memory side
   ////////////////////////////////////////////////////////////
   slot_sequencer slot_sequencer_inst (
      .CLK2(CLK2), .rst_n(rst_n),
      .snes_rd_n(snes_rd_n), .snes_wr_n(snes_wr_n),
      .avr_pending(avr_pending), .avr_write(avr_req.write),
      .is_saveram(is_saveram), .slot_ctl(slot_ctl)
   );

   addr_map addr_map_inst (
      .snes_addr(snes_addr), .avr_req(avr_req), .map_cfg(map_cfg),
      .avr_phase(slot_ctl.avr_phase), .sram_addr(sram_addr),
      .sram_ble_n(sram_ble_n), .sram_bhe_n(sram_bhe_n),
      .is_rom(is_rom), .is_saveram(is_saveram)
   );

   data_path data_path_inst (
      .CLK2(CLK2), .rst_n(rst_n),
      .slot_ctl(slot_ctl), .byte_hi(~sram_bhe_n),
      .snes_data_in(snes_data_in), .avr_wdata(avr_wdata),
      .sram_rdata(sram_rdata), .sram_wdata(sram_wdata), .sram_data_oe(sram_data_oe),
      .snes_data_out(snes_data_out), .avr_rd_byte(avr_rd_byte)
   );

endmodule

// ==== bench/cart_ctrl_tb.sv ====
`timescale 1ns/100ps

module cart_ctrl_tb;

   typedef enum logic [2:0] {
      op_set_map, op_set_save, op_avr_wr, op_avr_rd, op_con_rd, op_con_wr
   } op_e;

   typedef struct packed {
      op_e         op;
      logic [23:0] addr;
      logic [7:0]  data;
      logic        exp_oe;
   } entry_t;

   // Console address decoded to a physical SRAM byte
   typedef struct packed {
      logic        rom;
      logic        save;
      logic [20:0] phys;
   } map_t;

   logic                 CLK2;
   logic                 rst_n;
   logic [23:0]          snes_addr;
   logic                 snes_rd_n;
   logic                 snes_wr_n;
   logic [7:0]           snes_data_in;
   logic [7:0]           snes_data_out;
   logic                 snes_data_oe;
   logic                 snes_data_dir;
   logic                 spi_sck;
   logic                 spi_mosi;
   logic                 spi_ss;
   logic                 spi_miso;
   logic [19:0]          sram_addr;
   cart_pkg::sram_word_u sram_rdata;
   cart_pkg::sram_word_u sram_wdata;
   logic                 sram_data_oe;
   logic                 sram_oe_n;
   logic                 sram_we_n;
   logic                 sram_bhe_n;
   logic                 sram_ble_n;

   logic [15:0] mem [1 << 20];
   logic [15:0] exp_mem [1 << 20];
   entry_t      table_q [$];
   integer      seed;
   int          errors;
   int          model_errors;
   int          checks;
   logic        table_built;
   logic        cur_lorom;
   logic [19:0] cur_mask;

   cart_ctrl_top cart_ctrl_top_inst (.*);

   always #10 CLK2 = ~CLK2;

   ////////////////////////////////////////////////////////////
   // SRAM model
   ////////////////////////////////////////////////////////////
   assign sram_rdata = mem[sram_addr];

   always @(posedge CLK2) begin
      if (rst_n && !sram_oe_n && !sram_we_n) begin
         model_errors++;
         $display("Error at %0t: SRAM output enable and write enable low together", $time);
      end
      if (rst_n && !sram_we_n) begin
         if (!sram_data_oe) begin
            model_errors++;
            $display("Error at %0t: SRAM written while its data bus is not driven", $time);
         end
         // Only enabled lanes take the write
         if (!sram_bhe_n)
            mem[sram_addr][15:8] <= sram_wdata.bytes.hi;
         if (!sram_ble_n)
            mem[sram_addr][7:0] <= sram_wdata.bytes.lo;
      end
   end

   // Initial contents tied to every address bit
   function automatic logic [15:0] fill_word(input logic [19:0] a);
      return a[15:0] ^ {a[19:16], a[19:16], a[19:16], a[19:16]};
   endfunction

   function automatic logic [7:0] ref_byte(input logic [20:0] phys);
      return phys[0] ? exp_mem[phys[20:1]][15:8] : exp_mem[phys[20:1]][7:0];
   endfunction

   task automatic set_ref_byte(input logic [20:0] phys, input logic [7:0] b);
      if (phys[0])
         exp_mem[phys[20:1]][15:8] = b;
      else
         exp_mem[phys[20:1]][7:0] = b;
   endtask

   // Reference memory map for console addresses
   function automatic map_t map_console(input logic [23:0] a, input logic lorom,
                                        input logic [19:0] mask);
      map_t        m;
      logic [7:0]  bank;
      logic [15:0] offs;
      logic [21:0] rom_byte;
      logic [19:0] save_off;
      bank = a[23:16];
      offs = a[15:0];
      m = '0;
      if (lorom) begin
         m.rom    = offs[15];
         m.save   = (bank >= 8'h70) && (bank <= 8'h7D) && !offs[15];
         rom_byte = {bank[6:0], offs[14:0]};
         save_off = {1'b0, bank[3:0], offs[14:0]};
      end else begin
         m.rom    = ((bank >= 8'h40) && (bank <= 8'h7D)) || (bank >= 8'hC0) || offs[15];
         m.save   = (((bank >= 8'h20) && (bank <= 8'h3F)) || ((bank >= 8'hA0) && (bank <= 8'hBF)))
                    && (offs >= 16'h6000) && (offs <= 16'h7FFF);
         rom_byte = a[21:0];
         save_off = {7'd0, offs[12:0]};
      end
      if (m.save)
         m.phys = {cart_pkg::saveram_base, 1'b0} + 21'(save_off & mask);
      else
         m.phys = rom_byte[20:0];
      return m;
   endfunction

   task automatic report_mismatch(input string name, input logic [15:0] got,
                                  input logic [15:0] exp);
      errors++;
      $display("Error at %0t: %s = 0x%h, expected 0x%h", $time, name, got, exp);
   endtask

   ////////////////////////////////////////////////////////////
   // Bus tasks
   ////////////////////////////////////////////////////////////
   // 24 cycles strobe low, 6 high, outputs taken at cycle 20
   task automatic console_cycle(input logic [23:0] addr, input logic wr,
                                input logic [7:0] wdata, output logic oe,
                                output logic dir, output logic [7:0] rdata);
      snes_addr    = addr;
      snes_data_in = wdata;
      if (wr)
         snes_wr_n = 1'b0;
      else
         snes_rd_n = 1'b0;
      repeat (20) @(negedge CLK2);
      oe    = snes_data_oe;
      dir   = snes_data_dir;
      rdata = snes_data_out;
      repeat (4) @(negedge CLK2);
      snes_rd_n = 1'b1;
      snes_wr_n = 1'b1;
      repeat (6) @(negedge CLK2);
   endtask

   // Mode 0, SCK half period 4 cycles
   task automatic spi_byte(input logic [7:0] tx, output logic [7:0] rx);
      logic       oe;
      logic       dir;
      logic [7:0] rd;
      for (int b = 7; b >= 0; b--) begin
         spi_mosi = tx[b];
         repeat (4) @(negedge CLK2);
         rx[b]   = spi_miso;
         spi_sck = 1'b1;
         repeat (4) @(negedge CLK2);
         // One console cycle per byte gives the AVR its slots
         if (b == 0)
            console_cycle(24'h001000, 1'b0, 8'h00, oe, dir, rd);
         spi_sck = 1'b0;
      end
      repeat (4) @(negedge CLK2);
   endtask

   task automatic spi_select(input logic active);
      spi_ss = ~active;
      repeat (8) @(negedge CLK2);
   endtask

   task automatic send_address(input logic [23:0] addr);
      logic [7:0] rx;
      spi_select(1'b1);
      spi_byte({cart_pkg::cmd_set_addr, 4'h0}, rx);
      spi_byte(addr[23:16], rx);
      spi_byte(addr[15:8], rx);
      spi_byte(addr[7:0], rx);
      spi_select(1'b0);
   endtask

   task automatic send_command(input logic [7:0] cmd);
      logic [7:0] rx;
      spi_select(1'b1);
      spi_byte(cmd, rx);
      spi_select(1'b0);
   endtask

   ////////////////////////////////////////////////////////////
   // Stimulus table
   ////////////////////////////////////////////////////////////
   task automatic add_entry(input op_e op, input logic [23:0] addr, input logic [7:0] data,
                            input logic oe);
      table_q.push_back('{op: op, addr: addr, data: data, exp_oe: oe});
   endtask

   task automatic build_table;
      add_entry(op_set_map,  24'h000000, 8'(cart_pkg::map_hirom), 1'b0);
      add_entry(op_avr_wr,   24'h012345, 8'($random(seed)), 1'b0);
      add_entry(op_avr_wr,   24'h012344, 8'($random(seed)), 1'b0);
      add_entry(op_avr_wr,   24'h008124, 8'($random(seed)), 1'b0);
      add_entry(op_avr_wr,   24'h011234, 8'($random(seed)), 1'b0);
      add_entry(op_avr_wr,   24'h000011, 8'($random(seed)), 1'b0);
      add_entry(op_con_rd,   24'hC12345, 8'h00, 1'b1);
      add_entry(op_con_rd,   24'hC12344, 8'h00, 1'b1);
      add_entry(op_con_rd,   24'h008124, 8'h00, 1'b1);
      add_entry(op_con_rd,   24'h001000, 8'h00, 1'b0);
      add_entry(op_set_save, 24'h000000, 8'h03, 1'b0);
      add_entry(op_con_wr,   24'h206123, 8'($random(seed)), 1'b0);
      add_entry(op_con_rd,   24'h206123, 8'h00, 1'b1);
      // ROM write must not land
      add_entry(op_con_wr,   24'hC12345, 8'($random(seed)), 1'b0);
      add_entry(op_con_rd,   24'hC12345, 8'h00, 1'b1);
      add_entry(op_avr_rd,   24'h012345, 8'h00, 1'b0);
      add_entry(op_avr_rd,   24'h1E0123, 8'h00, 1'b0);
      add_entry(op_set_map,  24'h000000, 8'(cart_pkg::map_lorom), 1'b0);
      add_entry(op_con_rd,   24'h029234, 8'h00, 1'b1);
      add_entry(op_con_rd,   24'h808011, 8'h00, 1'b1);
      add_entry(op_con_rd,   24'h001000, 8'h00, 1'b0);
      add_entry(op_con_wr,   24'h702456, 8'($random(seed)), 1'b0);
      add_entry(op_avr_rd,   24'h1E0456, 8'h00, 1'b0);
      add_entry(op_avr_rd,   24'h000011, 8'h00, 1'b0);
   endtask

   task automatic apply_entry(input entry_t e);
      map_t       m;
      logic       oe;
      logic       dir;
      logic [7:0] rd;
      logic [7:0] rx;
      m = map_console(e.addr, cur_lorom, cur_mask);
      case (e.op)
         op_set_map: begin
            send_command({cart_pkg::cmd_set_map, e.data[3:0]});
            cur_lorom = (e.data[3:0] == cart_pkg::map_lorom);
         end
         op_set_save: begin
            send_command({cart_pkg::cmd_set_save, e.data[3:0]});
            // 1K shifted by the size code
            cur_mask = 20'((32'd1024 << e.data[3:0]) - 32'd1);
         end
         op_avr_wr: begin
            send_address(e.addr);
            spi_select(1'b1);
            spi_byte({cart_pkg::cmd_write, 4'h0}, rx);
            spi_byte(e.data, rx);
            spi_select(1'b0);
            set_ref_byte(e.addr[20:0], e.data);
            checks++;
            if (mem[e.addr[20:1]] !== exp_mem[e.addr[20:1]])
               report_mismatch("sram word", mem[e.addr[20:1]], exp_mem[e.addr[20:1]]);
         end
         op_avr_rd: begin
            send_address(e.addr);
            spi_select(1'b1);
            spi_byte({cart_pkg::cmd_read, 4'h0}, rx);
            spi_byte(8'h00, rx);
            // Read data trails the request by one byte
            spi_byte(8'h00, rx);
            spi_select(1'b0);
            checks++;
            if (rx !== ref_byte(e.addr[20:0]))
               report_mismatch("spi_miso byte", 16'(rx), 16'(ref_byte(e.addr[20:0])));
         end
         op_con_rd: begin
            console_cycle(e.addr, 1'b0, 8'h00, oe, dir, rd);
            checks++;
            if (oe !== e.exp_oe)
               report_mismatch("snes_data_oe", 16'(oe), 16'(e.exp_oe));
            if (dir !== 1'b1)
               report_mismatch("snes_data_dir", 16'(dir), 16'h0001);
            if (e.exp_oe && rd !== ref_byte(m.phys))
               report_mismatch("snes_data_out", 16'(rd), 16'(ref_byte(m.phys)));
         end
         default: begin
            console_cycle(e.addr, 1'b1, e.data, oe, dir, rd);
            if (m.save)
               set_ref_byte(m.phys, e.data);
            checks++;
            if (oe !== 1'b0)
               report_mismatch("snes_data_oe", 16'(oe), 16'h0000);
            // Console write turns the buffer away from the console
            if (dir !== 1'b0)
               report_mismatch("snes_data_dir", 16'(dir), 16'h0000);
            if (mem[m.phys[20:1]] !== exp_mem[m.phys[20:1]])
               report_mismatch("sram word", mem[m.phys[20:1]], exp_mem[m.phys[20:1]]);
         end
      endcase
   endtask

   ////////////////////////////////////////////////////////////
   // Main sequence
   ////////////////////////////////////////////////////////////
   initial begin
      CLK2         = 1'b0;
      rst_n        = 1'b0;
      snes_addr    = 24'h000000;
      snes_rd_n    = 1'b1;
      snes_wr_n    = 1'b1;
      snes_data_in = 8'h00;
      spi_sck      = 1'b0;
      spi_mosi     = 1'b0;
      spi_ss       = 1'b1;
      seed         = 32'h636fa6e9;
      errors       = 0;
      model_errors = 0;
      checks       = 0;
      table_built  = 1'b0;
      cur_lorom    = 1'b0;
      cur_mask     = 20'd0;
      for (int i = 0; i < (1 << 20); i++) begin
         mem[i]     <= fill_word(20'(i));
         exp_mem[i] = fill_word(20'(i));
      end
      build_table();
      table_built = 1'b1;
      repeat (2) @(negedge CLK2);
      rst_n = 1'b1;
      @(negedge CLK2);
      // Idle state straight after reset
      checks++;
      if (sram_oe_n !== 1'b1)
         report_mismatch("sram_oe_n", 16'(sram_oe_n), 16'h0001);
      if (sram_we_n !== 1'b1)
         report_mismatch("sram_we_n", 16'(sram_we_n), 16'h0001);
      if (snes_data_oe !== 1'b0)
         report_mismatch("snes_data_oe", 16'(snes_data_oe), 16'h0000);
      foreach (table_q[i])
         apply_entry(table_q[i]);
      repeat (10) @(negedge CLK2);
      $display("Checks: %0d, check errors: %0d, SRAM model errors: %0d",
               checks, errors, model_errors);
      if (errors == 0 && model_errors == 0)
         $display(">>> PASS");
      else
         $display(">>> FAIL");
      $finish;
   end

   // Watchdog, 16 us per table entry
   initial begin
      wait (table_built);
      #(table_q.size() * 400 * 40);
      $display("Error: simulation did not finish before the watchdog limit");
      $display(">>> FAIL");
      $finish;
   end

endmodule

// ==== cart_ctrl.f ====
source/cart_pkg.sv
source/spi_slave.sv
source/avr_cmd.sv
source/addr_map.sv
source/data_path.sv
source/slot_sequencer.sv
source/cart_ctrl_top.sv
bench/cart_ctrl_tb.sv

// ==== Makefile ====
# Verilator simulation of the cartridge memory controller

VERILATOR ?= verilator
TOP       ?= cart_ctrl_tb
FILELIST  ?= cart_ctrl.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= >>> PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -q -F '$(PASS_TEXT)'

clean:
	rm -rf $(BUILD_DIR)
